// File: verilog.f
source/lsu_pkg.sv
source/dcache_datapath.sv
source/dcache_way.sv
source/lsu_miss_fsm.sv
source/lsu.sv
sim/mem_bus_model.sv
sim/tb_lsu.sv

// File: Makefile
SIM := obj_dir/Vtb_lsu

.PHONY: all run lint clean

all: run

$(SIM): verilog.f source/*.sv sim/*.sv
	verilator --binary --timing --assert -f verilog.f --top-module tb_lsu -Mdir obj_dir

# pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	verilator --lint-only --timing -f verilog.f --top-module tb_lsu

clean:
	rm -rf obj_dir

// File: sim/tb_lsu.sv
module tb_lsu;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int    CYCLE_NS    = 100;
    localparam int    ROW_CNT     = 32;
    localparam int    REPEAT_FROM = 4;  // rows from here on run a second time with stalls
    localparam int    RUN_CNT     = 2 * ROW_CNT - REPEAT_FROM;
    localparam word_t FILL_KEY    = 32'h5a3c_96e1;
    localparam logic  LD          = 1'b0;
    localparam logic  ST          = 1'b1;
    localparam logic  CA          = 1'b0;
    localparam logic  UC          = 1'b1;
    localparam int    WB_CNT      = 6;

    // victim pointer is at way 1 when set 0x20 first fills
    localparam paddr_t WB_EXP [WB_CNT] = '{
        32'h0000_3200, 32'h0000_2200, 32'h0000_4200,
        32'h0000_2200, 32'h0000_3200, 32'h0000_4200
    };

    typedef struct packed {
        logic      write;
        mem_size_e size;
        paddr_t    addr;
        word_t     wdata;
        logic      unc;
    } row_t;

    // columns: op, size, address, store data, uncached
    row_t rows [ROW_CNT] = '{
        '{LD, SIZE_WORD, 32'h0000_0000, 32'h0000_0000, CA},  // first touches miss
        '{LD, SIZE_WORD, 32'h0000_0014, 32'h0000_0000, CA},
        '{LD, SIZE_BYTE, 32'h0000_0023, 32'h0000_0000, CA},
        '{LD, SIZE_HALF, 32'h0000_0036, 32'h0000_0000, CA},
        '{ST, SIZE_WORD, 32'h0000_0100, 32'h1122_3344, CA},  // merges and forwarding
        '{LD, SIZE_WORD, 32'h0000_0100, 32'h0000_0000, CA},
        '{ST, SIZE_BYTE, 32'h0000_0101, 32'h0000_00ab, CA},
        '{LD, SIZE_WORD, 32'h0000_0100, 32'h0000_0000, CA},
        '{ST, SIZE_HALF, 32'h0000_0102, 32'h0000_beef, CA},
        '{LD, SIZE_BYTE, 32'h0000_0103, 32'h0000_0000, CA},
        '{LD, SIZE_HALF, 32'h0000_0100, 32'h0000_0000, CA},
        '{ST, SIZE_BYTE, 32'h0000_0104, 32'h0000_005c, CA},
        '{LD, SIZE_WORD, 32'h0000_0104, 32'h0000_0000, CA},
        '{LD, SIZE_BYTE, 32'h0000_0105, 32'h0000_0000, CA},
        '{ST, SIZE_WORD, 32'h0000_2200, 32'ha0a0_0001, CA},  // set 0x20 conflicts
        '{LD, SIZE_WORD, 32'h0000_2200, 32'h0000_0000, CA},
        '{ST, SIZE_WORD, 32'h0000_3204, 32'hb0b0_0002, CA},
        '{LD, SIZE_WORD, 32'h0000_3204, 32'h0000_0000, CA},
        '{ST, SIZE_HALF, 32'h0000_420a, 32'h0000_c0c3, CA},
        '{LD, SIZE_WORD, 32'h0000_4208, 32'h0000_0000, CA},
        '{LD, SIZE_WORD, 32'h0000_2200, 32'h0000_0000, CA},
        '{LD, SIZE_WORD, 32'h0000_3204, 32'h0000_0000, CA},
        '{LD, SIZE_WORD, 32'h0000_5200, 32'h0000_0000, CA},  // two clean misses flush the set
        '{LD, SIZE_WORD, 32'h0000_620c, 32'h0000_0000, CA},
        '{LD, SIZE_WORD, 32'h0001_0000, 32'h0000_0000, UC},
        '{ST, SIZE_WORD, 32'h0001_0004, 32'h1357_9bdf, UC},
        '{LD, SIZE_WORD, 32'h0001_0004, 32'h0000_0000, UC},
        '{ST, SIZE_BYTE, 32'h0001_0009, 32'h0000_0077, UC},
        '{LD, SIZE_WORD, 32'h0001_0008, 32'h0000_0000, UC},
        '{ST, SIZE_HALF, 32'h0001_000e, 32'h0000_4242, UC},
        '{LD, SIZE_HALF, 32'h0001_000e, 32'h0000_0000, UC},
        '{LD, SIZE_BYTE, 32'h0001_0003, 32'h0000_0000, UC}
    };

    logic            clk = 1'b0;
    logic            rst_n;
    logic            req_valid;
    lsu_req_t        req;
    lsu_xlat_t       xlat;
    logic            stall_in;
    logic            busy;
    logic            done;
    word_t           r_data;
    cache_bus_req_t  bus_req;
    cache_bus_resp_t bus_resp;

    word_t  ref_mem [paddr_t];
    word_t  exp_data [RUN_CNT];
    int     pipe [$];          // run positions in M1 and M2, oldest first
    int     retired;
    int     unc_seen;

    always #(CYCLE_NS / 2) clk = ~clk;

    lsu i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .xlat_i      (xlat),
        .stall_i     (stall_in),
        .busy_o      (busy),
        .done_o      (done),
        .r_data_o    (r_data),
        .bus_req_o   (bus_req),
        .bus_resp_i  (bus_resp)
    );

    mem_bus_model #(.FILL_KEY(FILL_KEY)) i_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .req_i  (bus_req),
        .resp_o (bus_resp)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t exp, word_t got);
        if (got !== exp) abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic check_tag_ppn(string name, ppn_t exp, ppn_t got);
        if (got !== exp) abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic check_addr(string name, paddr_t exp, paddr_t got);
        if (got !== exp) abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    task automatic check_strb(string name, byte_en_t exp, byte_en_t got);
        if (got !== exp) abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, exp, got));
    endtask

    function automatic row_t row_at(int pos);
        return rows[pos < ROW_CNT ? pos : pos - ROW_CNT + REPEAT_FROM];
    endfunction

    function automatic word_t ref_read(paddr_t key);
        if (ref_mem.exists(key)) return ref_mem[key];
        return key ^ FILL_KEY;
    endfunction

    function automatic byte_en_t lanes_for(mem_size_e size, paddr_t addr);
        case (size)
            SIZE_BYTE: return byte_en_t'(4'b0001 << addr[1:0]);
            SIZE_HALF: return addr[1] ? 4'b1100 : 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic word_t size_mask(mem_size_e size);
        case (size)
            SIZE_BYTE: return 32'h0000_00ff;
            SIZE_HALF: return 32'h0000_ffff;
            default:   return 32'hffff_ffff;
        endcase
    endfunction

    // program order: expected load value and reference update at issue
    task automatic issue(int pos);
        row_t     r;
        paddr_t   key;
        word_t    w;
        word_t    sh;
        byte_en_t be;
        r   = row_at(pos);
        key = {r.addr[31:2], 2'b00};
        w   = ref_read(key);
        be  = lanes_for(r.size, r.addr);
        if (r.write) begin
            sh = r.wdata << (8 * r.addr[1:0]);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) w[b*8 +: 8] = sh[b*8 +: 8];
            end
            ref_mem[key] = w;
            exp_data[pos] = '0;
        end else begin
            exp_data[pos] = (w >> (8 * r.addr[1:0])) & size_mask(r.size);
        end
        req_valid = 1'b1;
        req       = '{write: r.write, size: r.size, vaddr: r.addr, wdata: r.wdata};
    endtask

    task automatic retire(int pos);
        row_t r;
        r = row_at(pos);
        if (!r.write) check_word("r_data_o", exp_data[pos], r_data);
        if (r.unc) begin
            unc_seen++;
            if (i_mem.unc_count != unc_seen) begin
                abort_run($sformatf("row %0d: %0d uncached bus accesses seen, %0d expected",
                                    pos, i_mem.unc_count, unc_seen));
            end
            check_addr("bus_req_o.addr", r.addr, i_mem.unc_addr);
            if (i_mem.unc_write !== r.write) abort_run("uncached access had the wrong direction");
            if (r.write) check_strb("bus_req_o.wstrb", lanes_for(r.size, r.addr), i_mem.unc_strb);
        end
    endtask

    task automatic check_write_backs();
        paddr_t line;
        if (i_mem.wb_lines.size() != WB_CNT) begin
            abort_run($sformatf("%0d dirty lines were written back, %0d expected",
                                i_mem.wb_lines.size(), WB_CNT));
        end
        for (int i = 0; i < WB_CNT; i++) begin
            line = i_mem.wb_lines[i];
            check_tag_ppn("bus_req_o.addr page", WB_EXP[i][31:12], line[31:12]);
            check_addr("bus_req_o.addr", WB_EXP[i], line);
            for (int k = 0; k < LINE_WORDS; k++) begin
                check_word("i_mem.mem", ref_read(line + paddr_t'(4 * k)),
                           i_mem.mem[line + paddr_t'(4 * k)]);
            end
        end
    endtask

    initial begin
        int   next_pos;
        int   ex_pos;
        int   m1_pos;
        logic ex_valid;
        logic stalled;
        row_t m1_row;
        void'($urandom(33749));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        xlat      = '0;
        stall_in  = 1'b0;
        next_pos  = 0;
        ex_pos    = 0;
        m1_pos    = -1;
        ex_valid  = 1'b0;
        stalled   = 1'b0;
        retired   = 0;
        unc_seen  = 0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(negedge clk);
        if (busy || done || bus_req.valid) abort_run("busy_o, done_o or bus valid high after reset");

        while (retired < RUN_CNT) begin
            @(posedge clk);
            #10;
            if (!stalled) begin
                if (next_pos < RUN_CNT) begin
                    issue(next_pos);
                    ex_pos   = next_pos;
                    ex_valid = 1'b1;
                    next_pos++;
                end else begin
                    req_valid = 1'b0;
                    ex_valid  = 1'b0;
                end
            end
            // identity translation of the request now in M1
            if (m1_pos >= 0) begin
                m1_row = row_at(m1_pos);
                xlat   = '{paddr: m1_row.addr, uncached: m1_row.unc};
            end else begin
                xlat = '0;
            end
            stall_in = (next_pos > ROW_CNT) && ($urandom_range(3) == 0);

            @(negedge clk);
            if (done && stall_in) abort_run("done_o rose while stall_i was high");
            stalled = busy || stall_in;
            if (done) begin
                if (pipe.size() == 0) abort_run("done_o pulsed with no request in flight");
                retire(pipe.pop_front());
                retired++;
            end
            if (!stalled) begin
                m1_pos = ex_valid ? ex_pos : -1;
                if (ex_valid) pipe.push_back(ex_pos);
            end
        end

        check_write_backs();
        $display("TEST PASSED");
        $finish;
    end

    // 200 cycles per applied row
    initial begin
        #(RUN_CNT * 200 * CYCLE_NS);
        abort_run($sformatf("timeout with %0d of %0d rows retired", retired, RUN_CNT));
    end

endmodule

// File: sim/mem_bus_model.sv
module mem_bus_model #(
    parameter lsu_pkg::word_t FILL_KEY = 32'h0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  lsu_pkg::cache_bus_req_t   req_i,
    output lsu_pkg::cache_bus_resp_t  resp_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    word_t    mem [paddr_t];  // word-aligned keys, missing words read as the fill pattern
    paddr_t   wb_lines [$];   // line address of each write-back burst
    int       unc_count;
    paddr_t   unc_addr;
    logic     unc_write;
    byte_en_t unc_strb;

    logic       active;
    paddr_t     base;
    logic       wr;
    logic       unc;
    logic [1:0] beat;
    int         gap;          // idle cycles before the next ready or data_ok
    paddr_t     key;
    word_t      w;

    function automatic word_t read_word(paddr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ FILL_KEY;
    endfunction

    assign key = unc ? {base[31:2], 2'b00} : {base[31:4], beat, 2'b00};

    always @(posedge clk) begin
        if (!rst_n) begin
            resp_o    <= '0;
            active    <= 1'b0;
            gap       <= 0;
            beat      <= 2'd0;
            unc_count = 0;
        end else begin
            resp_o.ready     <= 1'b0;
            resp_o.data_ok   <= 1'b0;
            resp_o.data_last <= 1'b0;
            if (!active) begin
                if (req_i.valid && resp_o.ready) begin  // address phase ends here
                    active <= 1'b1;
                    base   <= req_i.addr;
                    wr     <= req_i.write;
                    unc    <= req_i.uncached;
                    beat   <= 2'd0;
                    gap    <= $urandom_range(2);
                    if (req_i.uncached) begin
                        unc_count = unc_count + 1;
                        unc_addr  = req_i.addr;
                        unc_write = req_i.write;
                    end else if (req_i.write) begin
                        wb_lines.push_back(req_i.addr);
                    end
                end else if (req_i.valid && gap == 0) begin
                    resp_o.ready <= 1'b1;
                end else if (req_i.valid) begin
                    gap <= gap - 1;
                end
            end else if (resp_o.data_ok) begin
                // the beat moves at this edge
                if (wr && req_i.wvalid) begin
                    w = read_word(key);
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.wstrb[b]) w[b*8 +: 8] = req_i.wdata[b*8 +: 8];
                    end
                    mem[key] = w;
                    if (unc) unc_strb = req_i.wstrb;
                end
                if (resp_o.data_last) active <= 1'b0;
                beat <= beat + 2'd1;
                gap  <= $urandom_range(3);
            end else if (gap == 0) begin
                resp_o.data_ok   <= 1'b1;
                resp_o.data_last <= unc || beat == 2'd3;
                resp_o.rdata     <= read_word(key);
            end else begin
                gap <= gap - 1;
            end
        end
    end

endmodule

// File: source/lsu.sv
module lsu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid_i,
    input  lsu_pkg::lsu_req_t        req_i,
    input  lsu_pkg::lsu_xlat_t       xlat_i,
    input  logic                     stall_i,
    output logic                     busy_o,
    output logic                     done_o,
    output lsu_pkg::word_t           r_data_o,
    output lsu_pkg::cache_bus_req_t  bus_req_o,
    input  lsu_pkg::cache_bus_resp_t bus_resp_i
);
    import lsu_pkg::*;

    logic      stall, delay_stall, rsel_q, rsel_qq, hold;
    logic      m1_valid, m2_valid;
    lsu_req_t  m1_req, m2_req;
    lsu_xlat_t m2_xlat;

    tag_t  [WAY_CNT-1:0] way_tag, m2_tag;
    word_t [WAY_CNT-1:0] way_data, m2_data;
    logic  [WAY_CNT-1:0] hit, ram_mask, fill_way;

    ram_addr_t ram_raddr, ram_waddr, eng_raddr, fill_addr;
    byte_en_t  ram_we, fill_we, st_be;
    logic      ram_tag_we, fill_tag_we, fill_active, eng_rsel, store_we, start;
    word_t     ram_wdata, fill_data, st_data, victim_data, unc_rdata, ld_word, ld_shift;
    tag_t      ram_wtag, fill_tag;
    logic      unc_valid, unc_done, cached;

    assign stall = busy_o || stall_i;
    assign hold  = delay_stall && !rsel_q && !rsel_qq;  // raw reads right after engine use

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            delay_stall <= 1'b0;
            rsel_q      <= 1'b0;
            rsel_qq     <= 1'b0;
            m1_valid    <= 1'b0;
            m2_valid    <= 1'b0;
            unc_done    <= 1'b0;
        end else begin
            delay_stall <= stall;
            rsel_q      <= eng_rsel;
            rsel_qq     <= rsel_q;
            if (!stall) begin
                m1_valid <= req_valid_i;
                m2_valid <= m1_valid;
            end
            if (!stall) unc_done <= 1'b0;
            else if (unc_valid) unc_done <= 1'b1;
        end
    end

    // payload stages, plus fill updates of the held M2 line
    always_ff @(posedge clk) begin
        if (!stall) begin
            m1_req  <= req_i;
            m2_req  <= m1_req;
            m2_xlat <= xlat_i;
            m2_tag  <= way_tag;
            m2_data <= way_data;
        end else begin
            for (int w = 0; w < WAY_CNT; w++) begin
                if (fill_way[w] && fill_tag_we) m2_tag[w] <= fill_tag;
                if (fill_way[w] && |fill_we && fill_addr == m2_xlat.paddr[11:2]) begin
                    m2_data[w] <= fill_data;
                end
            end
        end
    end

    for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
        assign hit[w] = m2_tag[w].valid && m2_tag[w].ppn == m2_xlat.paddr[31:12];
        dcache_way i_way (
            .clk       (clk),
            .rst_n     (rst_n),
            .hold_i    (hold),
            .r_addr_i  (ram_raddr),
            .w_addr_i  (ram_waddr),
            .byte_en_i (ram_we & {4{ram_mask[w]}}),
            .tag_we_i  (ram_tag_we && ram_mask[w]),
            .w_data_i  (ram_wdata),
            .w_tag_i   (ram_wtag),
            .tag_o     (way_tag[w]),
            .data_o    (way_data[w])
        );
    end

    assign cached   = !m2_xlat.uncached;
    assign start    = m2_valid && (cached ? !(|hit) : !unc_done);
    assign done_o   = m2_valid && !stall;
    assign store_we = done_o && m2_req.write && cached;

    // byte lanes from size and low address bits
    always_comb begin
        case (m2_req.size)
            SIZE_BYTE: begin
                st_be   = 4'b0001 << m2_xlat.paddr[1:0];
                st_data = {4{m2_req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                st_be   = m2_xlat.paddr[1] ? 4'b1100 : 4'b0011;
                st_data = {2{m2_req.wdata[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = m2_req.wdata;
            end
        endcase
    end

    // RAM ports, engine first
    assign fill_active = |fill_we || fill_tag_we;
    assign ram_raddr   = eng_rsel ? eng_raddr : (stall ? m1_req.vaddr[11:2] : req_i.vaddr[11:2]);
    assign ram_waddr   = fill_active ? fill_addr : m2_xlat.paddr[11:2];
    assign ram_we      = fill_active ? fill_we : (store_we ? st_be : 4'b0);
    assign ram_tag_we  = fill_active ? fill_tag_we : store_we;
    assign ram_mask    = fill_active ? fill_way : hit;
    assign ram_wdata   = fill_active ? fill_data : st_data;
    assign ram_wtag    = fill_active ? fill_tag
                                     : '{valid: 1'b1, dirty: 1'b1, ppn: m2_xlat.paddr[31:12]};

    always_comb begin
        victim_data = '0;
        ld_word     = unc_rdata;
        for (int w = 0; w < WAY_CNT; w++) begin
            if (fill_way[w]) victim_data = way_data[w];
            if (cached && hit[w]) ld_word = m2_data[w];
        end
    end

    // zero-extended load result
    assign ld_shift = ld_word >> {m2_xlat.paddr[1:0], 3'b000};
    always_comb begin
        case (m2_req.size)
            SIZE_BYTE: r_data_o = {24'b0, ld_shift[7:0]};
            SIZE_HALF: r_data_o = {16'b0, ld_shift[15:0]};
            default:   r_data_o = ld_shift;
        endcase
    end

    lsu_miss_fsm i_miss_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start),
        .m2_paddr_i    (m2_xlat.paddr),
        .m2_write_i    (m2_req.write),
        .m2_uncached_i (m2_xlat.uncached),
        .m2_wdata_i    (st_data),
        .m2_wstrb_i    (st_be),
        .way_tag_i     (m2_tag),
        .way_data_i    (victim_data),
        .busy_o        (busy_o),
        .ram_raddr_o   (eng_raddr),
        .ram_rsel_o    (eng_rsel),
        .fill_we_o     (fill_we),
        .fill_way_o    (fill_way),
        .fill_addr_o   (fill_addr),
        .fill_data_o   (fill_data),
        .fill_tag_o    (fill_tag),
        .fill_tag_we_o (fill_tag_we),
        .unc_valid_o   (unc_valid),
        .unc_rdata_o   (unc_rdata),
        .bus_req_o     (bus_req_o),
        .bus_resp_i    (bus_resp_i)
    );

    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        m2_valid |-> $onehot0(hit));

endmodule

// File: source/lsu_miss_fsm.sv
module lsu_miss_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  lsu_pkg::paddr_t           m2_paddr_i,
    input  logic                      m2_write_i,
    input  logic                      m2_uncached_i,
    input  lsu_pkg::word_t            m2_wdata_i,
    input  lsu_pkg::byte_en_t         m2_wstrb_i,
    input  lsu_pkg::tag_t [lsu_pkg::WAY_CNT-1:0] way_tag_i,
    input  lsu_pkg::word_t            way_data_i,
    output logic                      busy_o,
    output lsu_pkg::ram_addr_t        ram_raddr_o,
    output logic                      ram_rsel_o,
    output lsu_pkg::byte_en_t         fill_we_o,
    output logic [lsu_pkg::WAY_CNT-1:0] fill_way_o,
    output lsu_pkg::ram_addr_t        fill_addr_o,
    output lsu_pkg::word_t            fill_data_o,
    output lsu_pkg::tag_t             fill_tag_o,
    output logic                      fill_tag_we_o,
    output logic                      unc_valid_o,
    output lsu_pkg::word_t            unc_rdata_o,
    output lsu_pkg::cache_bus_req_t   bus_req_o,
    input  lsu_pkg::cache_bus_resp_t  bus_resp_i
);
    import lsu_pkg::*;

    miss_state_e      state_q, state_d;
    logic [2:0]       cnt_q;
    logic [VIC_W-1:0] ptr_q, victim_q, victim_d;
    ppn_t             wb_ppn_q;
    word_t            line_buf [LINE_WORDS];
    word_t            unc_rdata_q;
    set_idx_t         set_idx;
    logic             beat, last_beat, victim_dirty;

    assign set_idx   = m2_paddr_i[11:4];
    assign beat      = bus_resp_i.data_ok;
    assign last_beat = bus_resp_i.data_ok && bus_resp_i.data_last;

    // first invalid way, else the pointer
    always_comb begin
        victim_d = ptr_q;
        for (int w = WAY_CNT - 1; w >= 0; w--) begin
            if (!way_tag_i[w].valid) victim_d = w[VIC_W-1:0];
        end
    end

    // dirty bit of an invalid way is stale
    assign victim_dirty = way_tag_i[victim_d].valid && way_tag_i[victim_d].dirty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            NORMAL: begin
                if (start_i && m2_uncached_i) state_d = m2_write_i ? PWADR : PRADR;
                else if (start_i) state_d = victim_dirty ? WB_READ : RADR;
            end
            WB_READ: if (cnt_q == 3'd4) state_d = WADR;
            WADR:    if (bus_resp_i.ready) state_d = WDAT;
            WDAT:    if (last_beat) state_d = RADR;
            RADR:    if (bus_resp_i.ready) state_d = RDAT;
            RDAT:    if (last_beat) state_d = NORMAL;
            PRADR:   if (bus_resp_i.ready) state_d = PRDAT;
            PRDAT:   if (last_beat) state_d = NORMAL;
            PWADR:   if (bus_resp_i.ready) state_d = PWDAT;
            PWDAT:   if (last_beat) state_d = NORMAL;
            default: state_d = NORMAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= NORMAL;
            cnt_q   <= '0;
            ptr_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q != state_d) cnt_q <= '0;
            else if (state_q == WB_READ) cnt_q <= cnt_q + 3'd1;
            else if ((state_q == WDAT || state_q == RDAT) && beat) cnt_q <= cnt_q + 3'd1;
            if (state_q == RDAT && last_beat) ptr_q <= ptr_q + 1'b1;  // toggle after refill
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == NORMAL && start_i) begin
            victim_q <= victim_d;
            wb_ppn_q <= way_tag_i[victim_d].ppn;
        end
        if (state_q == WB_READ && cnt_q != 3'd0) begin
            line_buf[cnt_q[1:0] - 2'd1] <= way_data_i;  // read returns one cycle late
        end
        if (state_q == PRDAT && beat) unc_rdata_q <= bus_resp_i.rdata;
    end

    assign busy_o      = (state_q != NORMAL) || start_i;
    assign ram_raddr_o = {set_idx, cnt_q[1:0]};
    assign ram_rsel_o  = (state_q == WB_READ) && (cnt_q < 3'd4);

    assign fill_way_o    = WAY_CNT'(1) << victim_q;
    assign fill_we_o     = (state_q == RDAT && beat) ? 4'hf : 4'h0;
    assign fill_addr_o   = {set_idx, cnt_q[1:0]};
    assign fill_data_o   = bus_resp_i.rdata;
    assign fill_tag_we_o = (state_q == RDAT) && last_beat;
    assign fill_tag_o    = '{valid: 1'b1, dirty: 1'b0, ppn: m2_paddr_i[31:12]};

    assign unc_valid_o = (state_q == PRDAT || state_q == PWDAT) && last_beat;
    assign unc_rdata_o = unc_rdata_q;

    always_comb begin
        bus_req_o = '0;
        case (state_q)
            WADR, WDAT: begin
                bus_req_o.valid  = (state_q == WADR);
                bus_req_o.write  = 1'b1;
                bus_req_o.addr   = {wb_ppn_q, set_idx, 4'b0};
                bus_req_o.wvalid = (state_q == WDAT);
                bus_req_o.wdata  = line_buf[cnt_q[1:0]];
                bus_req_o.wstrb  = 4'hf;
            end
            RADR: begin
                bus_req_o.valid = 1'b1;
                bus_req_o.addr  = {m2_paddr_i[31:4], 4'b0};
            end
            PRADR, PRDAT, PWADR, PWDAT: begin
                bus_req_o.valid    = (state_q == PRADR || state_q == PWADR);
                bus_req_o.write    = (state_q == PWADR || state_q == PWDAT);
                bus_req_o.uncached = 1'b1;
                bus_req_o.addr     = m2_paddr_i;
                bus_req_o.wvalid   = (state_q == PWDAT);
                bus_req_o.wdata    = m2_wdata_i;
                bus_req_o.wstrb    = m2_wstrb_i;
            end
            default: ;
        endcase
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_o.valid && !bus_resp_i.ready |=>
            bus_req_o.valid && $stable(bus_req_o.addr) && $stable(bus_req_o.write));

endmodule

// File: source/dcache_way.sv
module dcache_way (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold_i,
    input  lsu_pkg::ram_addr_t r_addr_i,
    input  lsu_pkg::ram_addr_t w_addr_i,
    input  lsu_pkg::byte_en_t  byte_en_i,
    input  logic               tag_we_i,
    input  lsu_pkg::word_t     w_data_i,
    input  lsu_pkg::tag_t      w_tag_i,
    output lsu_pkg::tag_t      tag_o,
    output lsu_pkg::word_t     data_o
);
    import lsu_pkg::*;

    word_t     raw_data, held_data, wb_data;
    tag_t      raw_tag, held_tag, wb_tag;
    ram_addr_t m1_r_addr, wb_addr;
    byte_en_t  wb_byte_en;
    logic      wb_tag_we;

    dcache_datapath i_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .r_addr_i  (r_addr_i),
        .w_addr_i  (w_addr_i),
        .data_we_i (byte_en_i),
        .tag_we_i  (tag_we_i),
        .data_i    (w_data_i),
        .tag_i     (w_tag_i),
        .data_o    (raw_data),
        .tag_o     (raw_tag)
    );

    // address of the read now at M1, and the write one stage on
    always_ff @(posedge clk) begin
        m1_r_addr <= r_addr_i;
        wb_addr   <= w_addr_i;
        wb_data   <= w_data_i;
        wb_tag    <= w_tag_i;
        held_data <= data_o;  // keeps forwarded writes too
        held_tag  <= tag_o;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_byte_en <= '0;
            wb_tag_we  <= 1'b0;
        end else begin
            wb_byte_en <= byte_en_i;
            wb_tag_we  <= tag_we_i;
        end
    end

    // M2 write has priority over WB write
    always_comb begin
        tag_o = hold_i ? held_tag : raw_tag;
        if (wb_tag_we && wb_addr[9:2] == m1_r_addr[9:2]) tag_o = wb_tag;
        if (tag_we_i && w_addr_i[9:2] == m1_r_addr[9:2]) tag_o = w_tag_i;
    end

    always_comb begin
        data_o = hold_i ? held_data : raw_data;
        for (int b = 0; b < 4; b++) begin
            if (wb_byte_en[b] && wb_addr == m1_r_addr) begin
                data_o[b*8 +: 8] = wb_data[b*8 +: 8];
            end
            if (byte_en_i[b] && w_addr_i == m1_r_addr) begin
                data_o[b*8 +: 8] = w_data_i[b*8 +: 8];
            end
        end
    end

endmodule

// File: source/dcache_datapath.sv
module dcache_datapath (
    input  logic              clk,
    input  logic              rst_n,
    input  lsu_pkg::ram_addr_t r_addr_i,
    input  lsu_pkg::ram_addr_t w_addr_i,
    input  lsu_pkg::byte_en_t data_we_i,
    input  logic              tag_we_i,
    input  lsu_pkg::word_t    data_i,
    input  lsu_pkg::tag_t     tag_i,
    output lsu_pkg::word_t    data_o,
    output lsu_pkg::tag_t     tag_o
);
    import lsu_pkg::*;

    word_t        data_mem [WAY_WORDS];
    logic [20:0]  tag_mem  [SET_CNT];  // dirty + ppn, valid lives in flops
    logic [SET_CNT-1:0] valid_q;
    logic [20:0]  tag_rd;
    logic         valid_rd;

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (data_we_i[b]) data_mem[w_addr_i][b*8 +: 8] <= data_i[b*8 +: 8];
        end
        if (tag_we_i) tag_mem[w_addr_i[9:2]] <= {tag_i.dirty, tag_i.ppn};
        data_o <= data_mem[r_addr_i];  // old content on same-edge write
        tag_rd <= tag_mem[r_addr_i[9:2]];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= '0;
            valid_rd <= 1'b0;
        end else begin
            if (tag_we_i) valid_q[w_addr_i[9:2]] <= tag_i.valid;
            valid_rd <= valid_q[r_addr_i[9:2]];
        end
    end

    assign tag_o = {valid_rd, tag_rd};

    a_no_x_tag: assert property (@(posedge clk) disable iff (!rst_n)
        tag_we_i && tag_i.valid |-> !$isunknown(tag_i));

endmodule

// File: source/lsu_pkg.sv
package lsu_pkg;

    // cache geometry
    localparam int WAY_CNT    = 2;
    localparam int LINE_WORDS = 4;
    localparam int SET_CNT    = 256;
    localparam int WAY_WORDS  = SET_CNT * LINE_WORDS;
    localparam int VIC_W      = $clog2(WAY_CNT);  // victim index width

    typedef logic [31:0] word_t;
    typedef logic [31:0] paddr_t;     // virtual or physical byte address
    typedef logic [9:0]  ram_addr_t;  // word index inside a way, addr[11:2]
    typedef logic [7:0]  set_idx_t;   // addr[11:4]
    typedef logic [19:0] ppn_t;
    typedef logic [3:0]  byte_en_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    typedef struct packed {
        logic valid;
        logic dirty;
        ppn_t ppn;
    } tag_t;

    typedef struct packed {
        logic      write;
        mem_size_e size;
        paddr_t    vaddr;
        word_t     wdata;
    } lsu_req_t;

    typedef struct packed {
        paddr_t paddr;
        logic   uncached;
    } lsu_xlat_t;

    typedef struct packed {
        logic     valid;     // address phase
        logic     write;
        logic     uncached;  // single word when set, else 4-word burst
        paddr_t   addr;
        logic     wvalid;
        word_t    wdata;
        byte_en_t wstrb;
    } cache_bus_req_t;

    typedef struct packed {
        logic  ready;
        logic  data_ok;
        logic  data_last;
        word_t rdata;
    } cache_bus_resp_t;

    typedef enum logic [3:0] {
        NORMAL, WB_READ, WADR, WDAT, RADR, RDAT, PRADR, PRDAT, PWADR, PWDAT
    } miss_state_e;

endpackage
